// ==== verilog/rnn_cfg.svh ====
`ifndef RNN_CFG_SVH
`define RNN_CFG_SVH

// network sizes
`define RNN_VOCAB_SIZE    76
`define RNN_EMBED_SIZE    4
`define RNN_HIDDEN_SIZE   8

// Q8.8 signed fixed point
`define RNN_DATA_WIDTH    16
`define RNN_FRAC_BITS     8

// weight store
`define RNN_ADDR_WIDTH    9

// section bases, 416 words in use
`define RNN_EMBED_BASE    0      // token*4 + e
`define RNN_W_IH_BASE     304    // n*4 + e
`define RNN_W_HH_BASE     336    // n*8 + k
`define RNN_B_IH_BASE     400    // n
`define RNN_B_HH_BASE     408    // n

`endif

// ==== verilog/rnn_pkg.sv ====
`include "rnn_cfg.svh"

package rnn_pkg;

    typedef logic [`RNN_DATA_WIDTH-1:0]              q_t;           // Q8.8 value
    typedef logic [`RNN_ADDR_WIDTH-1:0]              word_addr_t;
    typedef logic [$clog2(`RNN_VOCAB_SIZE)-1:0]      token_t;
    typedef logic [$clog2(`RNN_HIDDEN_SIZE)-1:0]     neuron_idx_t;
    typedef logic [$clog2(`RNN_HIDDEN_SIZE)-1:0]     slot_idx_t;    // embed or hidden index

    // which section a weight-store word belongs to
    typedef enum logic [2:0]
    {
        KIND_EMBED,
        KIND_W_HH,
        KIND_B_HH,
        KIND_W_IH,
        KIND_B_IH
    } param_kind_t;

    // read request from the sequencer
    typedef struct packed
    {
        word_addr_t  addr;
        param_kind_t kind;
        neuron_idx_t neuron;
        slot_idx_t   slot;
        logic        last_of_neuron;   // the b_ih word
        logic        last_of_step;     // b_ih of the last neuron
    } fetch_req_t;

    // RAM data with the request tag
    typedef struct packed
    {
        q_t          data;
        param_kind_t kind;
        neuron_idx_t neuron;
        slot_idx_t   slot;
        logic        last_of_neuron;
        logic        last_of_step;
    } param_word_t;

    typedef struct packed
    {
        word_addr_t addr;
        q_t         data;
    } weight_wr_t;

    typedef struct packed
    {
        neuron_idx_t index;
        q_t          value;
    } hidden_out_t;

endpackage

// ==== verilog/param_fetch.sv ====
`timescale 1ns/100ps
`include "rnn_cfg.svh"

module param_fetch import rnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  token_t     token,
    input  logic       step_done,
    output logic       busy,
    output logic       req_valid,
    output fetch_req_t req
);

    typedef enum logic [1:0] {ST_IDLE, ST_EMBED, ST_NEURON, ST_WAIT_DONE} state_t;

    state_t      state;
    param_kind_t kind;        // current section
    neuron_idx_t neuron;
    slot_idx_t   slot;
    token_t      token_q;
    logic        slot_wrap;   // last word of the section
    logic        last_neuron;
    word_addr_t  addr;

    assign busy        = (state != ST_IDLE);
    assign req_valid   = (state == ST_EMBED) || (state == ST_NEURON);
    assign last_neuron = (neuron == neuron_idx_t'(`RNN_HIDDEN_SIZE - 1));

    always_comb
    begin
        case (kind)
            KIND_W_HH:             slot_wrap = (slot == slot_idx_t'(`RNN_HIDDEN_SIZE - 1));
            KIND_EMBED, KIND_W_IH: slot_wrap = (slot == slot_idx_t'(`RNN_EMBED_SIZE - 1));
            default:               slot_wrap = 1'b1;   // biases are single words
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= ST_IDLE;
            kind   <= KIND_EMBED;
            neuron <= '0;
            slot   <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        state  <= ST_EMBED;
                        kind   <= KIND_EMBED;
                        neuron <= '0;
                        slot   <= '0;
                    end
                end
                ST_EMBED:
                begin
                    slot <= slot + slot_idx_t'(1);
                    if (slot_wrap)
                    begin
                        state <= ST_NEURON;
                        kind  <= KIND_W_HH;
                        slot  <= '0;
                    end
                end
                ST_NEURON:
                begin
                    slot <= slot + slot_idx_t'(1);
                    if (slot_wrap)
                    begin
                        slot <= '0;
                        case (kind)
                            KIND_W_HH: kind <= KIND_B_HH;
                            KIND_B_HH: kind <= KIND_W_IH;
                            KIND_W_IH: kind <= KIND_B_IH;
                            default:
                            begin
                                kind   <= KIND_W_HH;        // next neuron
                                neuron <= neuron + neuron_idx_t'(1);
                                if (last_neuron)
                                begin
                                    state <= ST_WAIT_DONE;
                                end
                            end
                        endcase
                    end
                end
                ST_WAIT_DONE:
                begin
                    if (step_done)
                    begin
                        state <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // token held for the whole step
    always_ff @(posedge clk)
    begin
        if (start && !busy)
        begin
            token_q <= token;
        end
    end

    always_comb
    begin
        case (kind)
            KIND_W_HH:
                addr = word_addr_t'(`RNN_W_HH_BASE)
                     + word_addr_t'(neuron) * word_addr_t'(`RNN_HIDDEN_SIZE)
                     + word_addr_t'(slot);
            KIND_B_HH:
                addr = word_addr_t'(`RNN_B_HH_BASE) + word_addr_t'(neuron);
            KIND_W_IH:
                addr = word_addr_t'(`RNN_W_IH_BASE)
                     + word_addr_t'(neuron) * word_addr_t'(`RNN_EMBED_SIZE)
                     + word_addr_t'(slot);
            KIND_B_IH:
                addr = word_addr_t'(`RNN_B_IH_BASE) + word_addr_t'(neuron);
            default:
                addr = word_addr_t'(`RNN_EMBED_BASE)
                     + word_addr_t'(token_q) * word_addr_t'(`RNN_EMBED_SIZE)
                     + word_addr_t'(slot);
        endcase
    end

    always_comb
    begin
        req.addr           = addr;
        req.kind           = kind;
        req.neuron         = neuron;
        req.slot           = slot;
        req.last_of_neuron = (kind == KIND_B_IH);
        req.last_of_step   = (kind == KIND_B_IH) && last_neuron;
    end

    // a start during a step never restarts the read sequence
    a_start_ignored: assert property (@(posedge clk) disable iff (reset)
        start && busy |=> !(state == ST_EMBED && slot == '0));

    // final request reaches step_done through store and MAC
    a_done_latency: assert property (@(posedge clk) disable iff (reset)
        req_valid && req.last_of_step |-> ##2 step_done);

    // no read right after step_done
    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        step_done |=> !req_valid);

endmodule

// ==== verilog/weight_store.sv ====
`timescale 1ns/100ps
`include "rnn_cfg.svh"

module weight_store import rnn_pkg::*;
(
    input  logic        clk,
    input  logic        wr_valid,
    input  weight_wr_t  wr,
    input  logic        req_valid,
    input  fetch_req_t  req,
    output logic        word_valid,
    output param_word_t word
);

    q_t mem [2**`RNN_ADDR_WIDTH];

    // loader write port
    always_ff @(posedge clk)
    begin
        if (wr_valid)
        begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, tag rides along
    always_ff @(posedge clk)
    begin
        word_valid          <= req_valid;
        word.data           <= mem[req.addr];
        word.kind           <= req.kind;
        word.neuron         <= req.neuron;
        word.slot           <= req.slot;
        word.last_of_neuron <= req.last_of_neuron;
        word.last_of_step   <= req.last_of_step;
    end

    // loader only runs between steps
    a_no_wr_during_rd: assert property (@(posedge clk)
        !(wr_valid && req_valid));

endmodule

// ==== verilog/neuron_mac.sv ====
`timescale 1ns/100ps
`include "rnn_cfg.svh"

module neuron_mac import rnn_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        word_valid,
    input  param_word_t word,
    output logic        hidden_valid,
    output hidden_out_t hidden,
    output logic        step_done
);

    localparam int PROD_WIDTH  = 2 * `RNN_DATA_WIDTH;
    localparam int EMBED_IDX_W = $clog2(`RNN_EMBED_SIZE);

    q_t embed_q [`RNN_EMBED_SIZE];   // embedding row of the token
    q_t old_h   [`RNN_HIDDEN_SIZE];  // committed state
    q_t new_h   [`RNN_HIDDEN_SIZE];  // this step's results
    q_t acc;
    q_t operand;
    q_t term;
    q_t acc_next;
    logic signed [PROD_WIDTH-1:0] product;

    // which kinds may follow which, with no gaps inside a step
    function automatic logic legal_after(param_kind_t prev, param_kind_t cur);
        logic ok;
        case (cur)
            KIND_W_HH: ok = (prev == KIND_EMBED) || (prev == KIND_B_IH) || (prev == KIND_W_HH);
            KIND_B_HH: ok = (prev == KIND_W_HH);
            KIND_W_IH: ok = (prev == KIND_B_HH) || (prev == KIND_W_IH);
            KIND_B_IH: ok = (prev == KIND_W_IH);
            default:   ok = 1'b1;
        endcase
        return ok;
    endfunction

    // W_hh uses the old state, W_ih the embedding
    always_comb
    begin
        if (word.kind == KIND_W_IH)
        begin
            operand = embed_q[word.slot[EMBED_IDX_W-1:0]];
        end
        else
        begin
            operand = old_h[word.slot];
        end
    end

    assign product = $signed(word.data) * $signed(operand);

    always_comb
    begin
        case (word.kind)
            KIND_W_HH, KIND_W_IH: term = product[`RNN_FRAC_BITS +: `RNN_DATA_WIDTH];
            default:              term = word.data;   // biases added as is
        endcase
        if (word.kind == KIND_W_HH && word.slot == '0)
        begin
            acc_next = term;   // first word of a neuron
        end
        else
        begin
            acc_next = acc + term;   // wraps mod 2^16
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hidden_valid <= 1'b0;
            step_done    <= 1'b0;
        end
        else
        begin
            hidden_valid <= word_valid && word.last_of_neuron;
            step_done    <= word_valid && word.last_of_step;
        end
    end

    always_ff @(posedge clk)
    begin
        if (word_valid)
        begin
            if (word.kind == KIND_EMBED)
            begin
                embed_q[word.slot[EMBED_IDX_W-1:0]] <= word.data;
            end
            else
            begin
                acc <= acc_next;
            end
            if (word.last_of_neuron)
            begin
                new_h[word.neuron] <= acc_next;
                hidden.index       <= word.neuron;
                hidden.value       <= acc_next;
            end
        end
    end

    // commit lands with step_done; last neuron comes straight from the adder
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `RNN_HIDDEN_SIZE; i++)
            begin
                old_h[i] <= '0;
            end
        end
        else if (word_valid && word.last_of_step)
        begin
            for (int i = 0; i < `RNN_HIDDEN_SIZE; i++)
            begin
                old_h[i] <= (word.neuron == neuron_idx_t'(i)) ? acc_next : new_h[i];
            end
        end
    end

    // fetch order W_hh, b_hh, W_ih, b_ih per neuron, after the embedding
    a_kind_order: assert property (@(posedge clk) disable iff (reset)
        word_valid && word.kind != KIND_EMBED |->
            $past(word_valid) && legal_after($past(word.kind), word.kind));

endmodule

// ==== verilog/rnn_cell_top.sv ====
`timescale 1ns/100ps

module rnn_cell_top import rnn_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        wr_valid,
    input  weight_wr_t  wr,
    input  logic        start,
    input  token_t      token,
    output logic        busy,
    output logic        hidden_valid,
    output hidden_out_t hidden,
    output logic        step_done
);

    logic        req_valid;
    fetch_req_t  req;
    logic        word_valid;
    param_word_t word;

    param_fetch u_fetch
    (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .token     (token),
        .step_done (step_done),   // ends busy
        .busy      (busy),
        .req_valid (req_valid),
        .req       (req)
    );

    weight_store u_store
    (
        .clk        (clk),
        .wr_valid   (wr_valid),
        .wr         (wr),
        .req_valid  (req_valid),
        .req        (req),
        .word_valid (word_valid),
        .word       (word)
    );

    neuron_mac u_mac
    (
        .clk          (clk),
        .reset        (reset),
        .word_valid   (word_valid),
        .word         (word),
        .hidden_valid (hidden_valid),
        .hidden       (hidden),
        .step_done    (step_done)
    );

endmodule

// ==== dv/rnn_tb_model.svh ====
`ifndef RNN_TB_MODEL_SVH
`define RNN_TB_MODEL_SVH

localparam int MODEL_WORDS = `RNN_B_HH_BASE + `RNN_HIDDEN_SIZE;   // 416 words in use

q_t mem_copy  [MODEL_WORDS];          // mirror of the weight store
q_t old_state [`RNN_HIDDEN_SIZE];     // committed hidden state
q_t expect_h  [`RNN_HIDDEN_SIZE];     // results of the step in flight

// Q8.8 multiply, full signed product then arithmetic shift
function automatic q_t q_mul(q_t a, q_t b);
    logic signed [31:0] p;
    p = $signed(a) * $signed(b);
    return q_t'(p >>> `RNN_FRAC_BITS);
endfunction

// one recurrent step from the mirror and the old state
function automatic void predict_step(token_t t);
    q_t sum;
    for (int n = 0; n < `RNN_HIDDEN_SIZE; n++)
    begin
        sum = '0;
        for (int k = 0; k < `RNN_HIDDEN_SIZE; k++)
        begin
            sum = sum + q_mul(mem_copy[`RNN_W_HH_BASE + n * `RNN_HIDDEN_SIZE + k], old_state[k]);
        end
        sum = sum + mem_copy[`RNN_B_HH_BASE + n];
        for (int e = 0; e < `RNN_EMBED_SIZE; e++)
        begin
            sum = sum + q_mul(mem_copy[`RNN_W_IH_BASE + n * `RNN_EMBED_SIZE + e],
                              mem_copy[int'(t) * `RNN_EMBED_SIZE + e]);   // embedding row
        end
        expect_h[n] = sum + mem_copy[`RNN_B_IH_BASE + n];   // wraps mod 2^16
    end
endfunction

function automatic void commit_state();
    for (int n = 0; n < `RNN_HIDDEN_SIZE; n++)
    begin
        old_state[n] = expect_h[n];
    end
endfunction

function automatic void clear_state();
    for (int n = 0; n < `RNN_HIDDEN_SIZE; n++)
    begin
        old_state[n] = '0;
    end
endfunction

`endif

// ==== dv/rnn_tb.sv ====
`timescale 1ns/100ps
`include "rnn_cfg.svh"

module rnn_tb
    import rnn_pkg::*;
();

    localparam int STEP_TIMEOUT = 400;   // a step takes about 120 cycles

    logic        clk = 1'b0;
    logic        reset;
    logic        wr_valid;
    weight_wr_t  wr;
    logic        start;
    token_t      token;
    logic        busy;
    logic        hidden_valid;
    hidden_out_t hidden;
    logic        step_done;
    token_t      tok;

    `include "rnn_tb_model.svh"

    rnn_cell_top u_dut
    (
        .clk          (clk),
        .reset        (reset),
        .wr_valid     (wr_valid),
        .wr           (wr),
        .start        (start),
        .token        (token),
        .busy         (busy),
        .hidden_valid (hidden_valid),
        .hidden       (hidden),
        .step_done    (step_done)
    );

    always #5 clk = ~clk;

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic abort_with(string why);
        $display("%0t: %s", $time, why);
        stop_run();
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp)
        begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_hidden(string name, hidden_out_t exp, hidden_out_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %0t %s expected index %0d value %h actual index %0d value %h",
                     $time, name, exp.index, exp.value, act.index, act.value);
            stop_run();
        end
    endtask

    function automatic q_t rand_q();
        int v;
        v = int'($urandom % 1025) - 512;   // within +-2.0
        return q_t'(v);
    endfunction

    function automatic token_t rand_token();
        return token_t'($urandom % `RNN_VOCAB_SIZE);
    endfunction

    task automatic write_word(int a, q_t d);
        @(posedge clk);
        #1;
        wr_valid = 1'b1;
        wr.addr  = word_addr_t'(a);
        wr.data  = d;
        mem_copy[a] = d;
    endtask

    task automatic end_writes();
        @(posedge clk);
        #1;
        wr_valid = 1'b0;
    endtask

    task automatic start_step(token_t t);
        @(posedge clk);
        #1;
        start = 1'b1;
        token = t;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    // reset pulse mid-step after which outputs must go quiet
    task automatic reset_mid_step();
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int i = 0; i < 5; i++)
        begin
            @(negedge clk);
            if (i > 0)   // first edge under reset not yet seen at i == 0
            begin
                check_flag("busy", 1'b0, busy);
                check_flag("hidden_valid", 1'b0, hidden_valid);
                check_flag("step_done", 1'b0, step_done);
            end
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 20; i++)
        begin
            @(negedge clk);
            check_flag("busy", 1'b0, busy);
            check_flag("hidden_valid", 1'b0, hidden_valid);
            check_flag("step_done", 1'b0, step_done);
        end
        clear_state();
    endtask

    // inject_at and reset_at count sampled cycles after start and -1 disables them
    task automatic run_step(token_t t, int inject_at, token_t other, int reset_at);
        int          count;
        int          cyc;
        logic        done;
        hidden_out_t exp;
        predict_step(t);
        start_step(t);
        count = 0;
        cyc   = 0;
        done  = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            cyc++;
            if (cyc > STEP_TIMEOUT)
            begin
                abort_with("timeout while waiting for step_done");
            end
            if (hidden_valid)
            begin
                if (count >= `RNN_HIDDEN_SIZE)
                begin
                    abort_with("more than eight hidden outputs in one step");
                end
                exp.index = neuron_idx_t'(count);
                exp.value = expect_h[count];
                check_hidden("hidden", exp, hidden);
                count++;
            end
            if (step_done)
            begin
                if (count != `RNN_HIDDEN_SIZE)
                begin
                    abort_with($sformatf("step_done came after only %0d hidden outputs", count));
                end
                done = 1'b1;
            end
            else
            begin
                check_flag("busy", 1'b1, busy);
            end
            if (cyc == inject_at)
            begin
                @(posedge clk);
                #1;
                start = 1'b1;   // must be ignored while busy
                token = other;
            end
            if (cyc == inject_at + 1)
            begin
                @(posedge clk);
                #1;
                start = 1'b0;
            end
            if (cyc == reset_at)
            begin
                reset_mid_step();
                return;
            end
        end
        @(negedge clk);
        check_flag("step_done", 1'b0, step_done);   // single pulse
        check_flag("busy", 1'b0, busy);
        commit_state();
    endtask

    initial
    begin
        void'($urandom(32'hfb87_7516));
        reset    = 1'b1;
        wr_valid = 1'b0;
        wr       = '0;
        start    = 1'b0;
        token    = '0;
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;
        clear_state();
        @(negedge clk);
        check_flag("busy", 1'b0, busy);
        check_flag("hidden_valid", 1'b0, hidden_valid);
        check_flag("step_done", 1'b0, step_done);

        // check 1 does a full load and a first step from zero state
        for (int a = 0; a < MODEL_WORDS; a++)
        begin
            write_word(a, rand_q());
        end
        end_writes();
        run_step(rand_token(), -1, '0, -1);

        // check 2 runs the recurrence
        for (int s = 0; s < 5; s++)
        begin
            run_step(rand_token(), -1, '0, -1);
        end

        // check 3 pulses start while busy
        tok = rand_token();
        run_step(tok, 30, token_t'((int'(tok) + 1) % `RNN_VOCAB_SIZE), -1);

        // check 4 resets mid-step and then runs a clean step
        run_step(rand_token(), -1, '0, 45);
        run_step(rand_token(), -1, '0, -1);

        // check 5 rewrites an embedding row, the biases and a few random words
        tok = rand_token();
        for (int e = 0; e < `RNN_EMBED_SIZE; e++)
        begin
            write_word(int'(tok) * `RNN_EMBED_SIZE + e, rand_q());
        end
        for (int n = 0; n < `RNN_HIDDEN_SIZE; n++)
        begin
            write_word(`RNN_B_IH_BASE + n, rand_q());
            write_word(`RNN_B_HH_BASE + n, rand_q());
        end
        for (int i = 0; i < 6; i++)
        begin
            write_word(int'($urandom % MODEL_WORDS), rand_q());
        end
        end_writes();
        run_step(tok, -1, '0, -1);
        run_step(rand_token(), -1, '0, -1);

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verilog
+incdir+dv
verilog/rnn_pkg.sv
verilog/param_fetch.sv
verilog/weight_store.sv
verilog/neuron_mac.sv
verilog/rnn_cell_top.sv
dv/rnn_tb.sv

// ==== Bender.yml ====
package:
  name: rnn_cell

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rnn_pkg.sv
      - verilog/param_fetch.sv
      - verilog/weight_store.sv
      - verilog/neuron_mac.sv
      - verilog/rnn_cell_top.sv
  - target: test
    include_dirs:
      - verilog
      - dv
    files:
      - dv/rnn_tb.sv
